/* soc_top.f */
+incdir+include
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/mem_port_if.sv
rtl/soc_bus_router.sv
rtl/l2_mem.sv
rtl/ctrl_regs.sv
rtl/soc_top.sv
bench/tb_soc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --assert --top-module tb_soc_top -f soc_top.f -o tb_soc_top > "$log" 2>&1 \
  && ./obj_dir/tb_soc_top >> "$log" 2>&1 \
  || echo "Build or simulation did not complete" >> "$log"
cat "$log"
grep -q "TEST FAILED" "$log" && exit 1 || grep -q "TEST OK" "$log" || exit 1

/* bench/tb_soc_top.sv */
/*
 * SoC memory-side testbench
 * LFSR traffic to L2, control registers and unmapped space against a shadow model
 */

`timescale 1ns/100ps

`include "soc_defs.svh"

module tb_soc_top import soc_bus_pkg::*; ();

  // About 220 cycles of traffic plus a wide margin
  localparam int max_cycles = 2000;

  typedef struct packed {
    logic [31:0] due;
    logic        err;
    bus_data_t   data;
    bus_data_t   mask;
    bus_data_t   exit_v;
    bus_data_t   hw_v;
  } exp_rsp_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        bus_req_i;
  logic        bus_we_i;
  bus_addr_t   bus_addr_i;
  bus_strb_t   bus_be_i;
  bus_data_t   bus_wdata_i;
  logic        bus_rvalid_o;
  bus_data_t   bus_rdata_o;
  logic        bus_err_o;
  bus_data_t   exit_o;
  bus_data_t   hw_cnt_en_o;

  exp_rsp_t    exp_q [$];
  bus_data_t   shadow_mem [64];
  bus_data_t   shadow_mask [64];
  logic        touched [64];
  bus_data_t   exit_sh;
  bus_data_t   hw_sh;
  logic [15:0] lfsr;
  int          cyc = 0;
  int          pulse_cnt = 0;
  int          rsp_err_cnt = 0;
  int          seq_err_cnt = 0;
  int          err_mark = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  soc_top UUT (.*);

  always #5 clk_i = ~clk_i;

  // Cycle count and watchdog
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc == max_cycles) begin
      $display("Timeout: run still busy after %0d cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR over x^16 + x^14 + x^13 + x^11 + 1
  function automatic bus_data_t rand_bits(input int n);
    bus_data_t v;
    logic      fb;
    int        i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic bus_addr_t l2_addr(input logic [5:0] word);
    return `SOC_DRAM_BASE + {23'd0, word, 3'd0};
  endfunction

  function automatic bus_addr_t ctrl_addr(input logic [1:0] sel);
    return `SOC_CTRL_BASE + {27'd0, sel, 3'd0};
  endfunction

  // One request per cycle with its expected answer queued for the next cycle
  task automatic issue(input logic we, input bus_addr_t addr, input bus_strb_t be,
                       input bus_data_t wdata);
    exp_rsp_t   e;
    bus_data_t  m;
    logic [5:0] idx;
    int         i;
    @(posedge clk_i);
    #1;
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    for (i = 0; i < 8; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    e      = '0;
    e.due  = cyc + 1;
    e.mask = '1;
    if (addr >= `SOC_DRAM_BASE && addr < `SOC_DRAM_BASE + `SOC_DRAM_LEN) begin
      // Only the first 64 words are used
      idx = addr[8:3];
      if (we) begin
        shadow_mem[idx]  = (shadow_mem[idx] & ~m) | (wdata & m);
        shadow_mask[idx] = shadow_mask[idx] | m;
        touched[idx]     = 1'b1;
      end else begin
        e.data = shadow_mem[idx];
        e.mask = shadow_mask[idx];
      end
    end else if (addr >= `SOC_CTRL_BASE && addr < `SOC_CTRL_BASE + `SOC_CTRL_LEN) begin
      if (we && addr[4:3] == 2'd0) begin
        exit_sh = (exit_sh & ~m) | (wdata & m);
      end else if (we && addr[4:3] == 2'd1) begin
        hw_sh = (hw_sh & ~m) | (wdata & m);
      end else if (!we) begin
        case (addr[4:3])
          2'd0:    e.data = exit_sh;
          2'd1:    e.data = hw_sh;
          2'd2:    e.data = 64'h0000_0000_8000_0000;
          default: e.data = 64'h0000_0000_8000_2000;
        endcase
      end
    end else begin
      e.err = 1'b1;
    end
    e.exit_v = exit_sh;
    e.hw_v   = hw_sh;
    exp_q.push_back(e);
  endtask

  task automatic read_at(input bus_addr_t addr);
    issue(1'b0, addr, '0, '0);
  endtask

  // Stop requesting and wait for every answer
  task automatic drain();
    @(posedge clk_i);
    #1;
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = rsp_err_cnt + seq_err_cnt - err_mark;
    tests_run++;
    if (n != 0) begin
      tests_failed++;
    end
    $display("%s: %s, %0d errors", name, (n == 0) ? "passed" : "failed", n);
    err_mark = rsp_err_cnt + seq_err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Response checks sampled mid-cycle
  ////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic got);
    assert (got === exp) else begin
      $display("** Error: %s expected %h, got %h at %0t", name, exp, got, $time);
      rsp_err_cnt++;
    end
  endtask

  task automatic check_word(input string name, input bus_data_t exp, input bus_data_t got);
    assert (got === exp) else begin
      $display("** Error: %s expected %h, got %h at %0t", name, exp, got, $time);
      rsp_err_cnt++;
    end
  endtask

  always @(negedge clk_i) begin
    exp_rsp_t e;
    if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      check_bit("bus_rvalid_o", 1'b1, bus_rvalid_o);
      check_bit("bus_err_o", e.err, bus_err_o);
      // Bytes never written are undefined in L2
      check_word("bus_rdata_o", e.data & e.mask, bus_rdata_o & e.mask);
      check_word("exit_o", e.exit_v, exit_o);
      check_word("hw_cnt_en_o", e.hw_v, hw_cnt_en_o);
    end else begin
      check_bit("bus_rvalid_o", 1'b0, bus_rvalid_o);
      check_bit("bus_err_o", 1'b0, bus_err_o);
      check_word("bus_rdata_o", '0, bus_rdata_o);
      if (exp_q.size() == 0) begin
        check_word("exit_o", exit_sh, exit_o);
        check_word("hw_cnt_en_o", hw_sh, hw_cnt_en_o);
      end
    end
    if (bus_rvalid_o) begin
      pulse_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    bus_data_t a;
    bus_data_t b;
    bus_data_t d;
    int        i;
    int        p0;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_be_i    = '0;
    bus_wdata_i = '0;
    lfsr        = 16'd33381;
    exit_sh     = '0;
    hw_sh       = '0;
    shadow_mem  = '{default: '0};
    shadow_mask = '{default: '0};
    touched     = '{default: 1'b0};

    // Reset state is watched by the monitor during and after reset
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    repeat (2) @(negedge clk_i);
    end_test("reset state");

    // Random L2 writes and a read of every touched word
    for (i = 0; i < 64; i++) begin
      a = rand_bits(6);
      b = rand_bits(8);
      d = rand_bits(64);
      issue(1'b1, l2_addr(a[5:0]), b[7:0], d);
    end
    for (i = 0; i < 64; i++) begin
      if (touched[i[5:0]]) begin
        read_at(l2_addr(i[5:0]));
      end
    end
    drain();
    end_test("l2 byte enables");

    // Back-to-back mixed stream
    p0 = pulse_cnt;
    for (i = 0; i < 32; i++) begin
      a = rand_bits(7);
      b = rand_bits(8);
      d = rand_bits(64);
      issue(a[6], l2_addr(a[5:0]), b[7:0], d);
    end
    drain();
    assert (pulse_cnt - p0 == 32) else begin
      $display("Stream of 32 requests gave %0d responses", pulse_cnt - p0);
      seq_err_cnt++;
    end
    end_test("pipelined stream");

    // Control registers with read-only DRAM bounds
    d = rand_bits(64);
    issue(1'b1, ctrl_addr(2'd0), 8'h0F, d);
    d = rand_bits(64);
    issue(1'b1, ctrl_addr(2'd1), 8'h3C, d);
    read_at(ctrl_addr(2'd0));
    read_at(ctrl_addr(2'd1));
    d = rand_bits(64);
    issue(1'b1, ctrl_addr(2'd0), 8'hA5, d);
    read_at(ctrl_addr(2'd0));
    issue(1'b1, ctrl_addr(2'd2), 8'hFF, '1);
    issue(1'b1, ctrl_addr(2'd3), 8'hFF, '0);
    read_at(ctrl_addr(2'd2));
    read_at(ctrl_addr(2'd3));
    drain();
    end_test("control registers");

    // Fully written L2 words that a stray unmapped write would land on
    for (i = 0; i < 4; i++) begin
      d = rand_bits(64);
      issue(1'b1, l2_addr(i[5:0]), 8'hFF, d);
    end

    // Unmapped space followed by reads of L2 and control registers
    d = rand_bits(64);
    issue(1'b1, 32'h0000_1000, 8'hFF, d);
    read_at(32'hC000_0000);
    issue(1'b1, 32'hC000_0000, 8'hFF, d);
    issue(1'b1, 32'h8000_2000, 8'hFF, d);
    read_at(32'hD000_1000);
    read_at(32'h7FFF_FFF8);
    for (i = 0; i < 4; i++) begin
      read_at(l2_addr(i[5:0]));
    end
    read_at(ctrl_addr(2'd0));
    read_at(ctrl_addr(2'd1));
    drain();
    end_test("unmapped access");

    $display("Tests run %0d, failed %0d, check errors %0d, responses %0d",
             tests_run, tests_failed, rsp_err_cnt + seq_err_cnt, pulse_cnt);
    if (tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* rtl/soc_top.sv */
/*
 * SoC memory-side top
 * Host port routed by address to the L2 memory and the control registers
 */

`timescale 1ns/100ps

module soc_top import soc_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host request
  input  logic      bus_req_i,
  input  logic      bus_we_i,
  input  bus_addr_t bus_addr_i,
  input  bus_strb_t bus_be_i,
  input  bus_data_t bus_wdata_i,
  // Host response
  output logic      bus_rvalid_o,
  output bus_data_t bus_rdata_o,
  output logic      bus_err_o,
  // Control outputs
  output bus_data_t exit_o,
  output bus_data_t hw_cnt_en_o
);

  //////////////////////////////////////////////////////////////////////
  // Router
  //////////////////////////////////////////////////////////////////////

  mem_port_if l2_port ();
  mem_port_if ctrl_port ();

  soc_bus_router i_router (
    .clk_i      (clk_i       ),
    .rst_n_i    (rst_n_i     ),
    .bus_req_i  (bus_req_i   ),
    .bus_we_i   (bus_we_i    ),
    .bus_addr_i (bus_addr_i  ),
    .bus_be_i   (bus_be_i    ),
    .bus_wdata_i(bus_wdata_i ),
    .rsp_valid_o(bus_rvalid_o),
    .rsp_data_o (bus_rdata_o ),
    .rsp_err_o  (bus_err_o   ),
    .l2_port    (l2_port     ),
    .ctrl_port  (ctrl_port   )
  );

  //////////////////////////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////////////////////////

  l2_mem i_l2_mem (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .port   (l2_port)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .port       (ctrl_port  ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

/* rtl/ctrl_regs.sv */
/*
 * SoC control registers
 * Exit code, counter enable and the read-only DRAM window bounds
 */

`timescale 1ns/100ps

`include "soc_defs.svh"

module ctrl_regs import soc_bus_pkg::*; import soc_map_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  mem_port_if.target port,
  output bus_data_t exit_o,
  output bus_data_t hw_cnt_en_o
);

  localparam int unsigned off_w     = $clog2(`SOC_STRB_W);
  localparam int unsigned sel_w     = $bits(ctrl_reg_e);
  localparam bus_data_t   dram_base = bus_data_t'(`SOC_DRAM_BASE);
  localparam bus_data_t   dram_end  = dram_base + bus_data_t'(`SOC_DRAM_LEN);

  ctrl_reg_e reg_sel;
  bus_data_t exit_q;
  bus_data_t hw_cnt_en_q;
  bus_data_t rd_word;
  bus_data_t rdata_q;
  logic      rvalid_q;

  // One register per 64-bit word
  assign reg_sel = ctrl_reg_e'(port.addr[off_w +: sel_w]);

  //////////////////////////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= port.req;
      if (port.req && port.we) begin
        case (reg_sel)
          REG_EXIT:      exit_q      <= strb_merge(exit_q, port.wdata, port.be);
          REG_HW_CNT_EN: hw_cnt_en_q <= strb_merge(hw_cnt_en_q, port.wdata, port.be);
          // Window bounds are fixed
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register reads
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_sel)
      REG_EXIT:      rd_word = exit_q;
      REG_HW_CNT_EN: rd_word = hw_cnt_en_q;
      REG_DRAM_BASE: rd_word = dram_base;
      REG_DRAM_END:  rd_word = dram_end;
    endcase
  end

  // Zero for writes and idle cycles
  always_ff @(posedge clk_i) begin
    rdata_q <= (port.req && !port.we) ? rd_word : '0;
  end

  assign port.rdata  = rdata_q;
  assign port.rvalid = rvalid_q;

  assign exit_o      = exit_q;
  assign hw_cnt_en_o = hw_cnt_en_q;

endmodule

/* rtl/l2_mem.sv */
/*
 * L2 memory
 * Single-port word storage with byte enables and one-cycle read latency
 */

`timescale 1ns/100ps

`include "soc_defs.svh"

module l2_mem import soc_bus_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  mem_port_if.target port
);

  localparam int unsigned off_w = $clog2(`SOC_STRB_W);
  localparam int unsigned idx_w = $clog2(`SOC_L2_WORDS);

  bus_data_t        mem_q [`SOC_L2_WORDS];
  logic [idx_w-1:0] idx;
  bus_data_t        rdata_q;
  logic             rvalid_q;

  // Word index, byte offset dropped
  assign idx = port.addr[off_w +: idx_w];

  // Write lands at the edge that samples req
  always_ff @(posedge clk_i) begin
    if (port.req && port.we) begin
      mem_q[idx] <= strb_merge(mem_q[idx], port.wdata, port.be);
    end
  end

  // Zero for writes and idle cycles
  always_ff @(posedge clk_i) begin
    rdata_q <= (port.req && !port.we) ? mem_q[idx] : '0;
  end

  // Always granted, answer follows one cycle later
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= port.req;
    end
  end

  assign port.rdata  = rdata_q;
  assign port.rvalid = rvalid_q;

endmodule

/* rtl/soc_bus_router.sv */
/*
 * SoC bus router
 * Decodes host requests to the L2 or the control registers and merges responses
 */

`timescale 1ns/100ps

`include "soc_defs.svh"

module soc_bus_router import soc_bus_pkg::*; import soc_map_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Host request
  input  logic      bus_req_i,
  input  logic      bus_we_i,
  input  bus_addr_t bus_addr_i,
  input  bus_strb_t bus_be_i,
  input  bus_data_t bus_wdata_i,
  // Host response
  output logic      rsp_valid_o,
  output bus_data_t rsp_data_o,
  output logic      rsp_err_o,
  // Targets
  mem_port_if.initiator l2_port,
  mem_port_if.initiator ctrl_port
);

  bus_addr_t   l2_off;
  bus_addr_t   ctrl_off;
  logic        l2_hit;
  logic        ctrl_hit;
  soc_target_e tgt;
  soc_target_e tag_q;
  logic        err_pend_q;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  // Offset into each window, wraps below the base
  assign l2_off   = bus_addr_i - bus_addr_t'(`SOC_DRAM_BASE);
  assign ctrl_off = bus_addr_i - bus_addr_t'(`SOC_CTRL_BASE);
  assign l2_hit   = l2_off < bus_addr_t'(`SOC_DRAM_LEN);
  assign ctrl_hit = ctrl_off < bus_addr_t'(`SOC_CTRL_LEN);

  always_comb begin
    if (l2_hit) begin
      tgt = TGT_L2;
    end else if (ctrl_hit) begin
      tgt = TGT_CTRL;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // Strobe only the selected target
  assign l2_port.req   = bus_req_i && (tgt == TGT_L2);
  assign l2_port.we    = bus_we_i;
  assign l2_port.addr  = bus_addr_i;
  assign l2_port.be    = bus_be_i;
  assign l2_port.wdata = bus_wdata_i;

  assign ctrl_port.req   = bus_req_i && (tgt == TGT_CTRL);
  assign ctrl_port.we    = bus_we_i;
  assign ctrl_port.addr  = bus_addr_i;
  assign ctrl_port.be    = bus_be_i;
  assign ctrl_port.wdata = bus_wdata_i;

  //////////////////////////////////////////////////////////////////////
  // Response select
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tag_q      <= TGT_NONE;
      err_pend_q <= 1'b0;
    end else begin
      if (bus_req_i) begin
        tag_q <= tgt;
      end
      err_pend_q <= bus_req_i && (tgt == TGT_NONE);
    end
  end

  always_comb begin
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    rsp_err_o   = 1'b0;
    case (tag_q)
      TGT_L2: begin
        rsp_valid_o = l2_port.rvalid;
        rsp_data_o  = l2_port.rvalid ? l2_port.rdata : '0;
      end
      TGT_CTRL: begin
        rsp_valid_o = ctrl_port.rvalid;
        rsp_data_o  = ctrl_port.rvalid ? ctrl_port.rdata : '0;
      end
      default: begin
        // Unmapped, answered here with an error
        rsp_valid_o = err_pend_q;
        rsp_err_o   = err_pend_q;
      end
    endcase
  end

endmodule

/* rtl/mem_port_if.sv */
/*
 * Memory-style port
 * Request strobes from the router, read data and valid back from a target
 */

`timescale 1ns/100ps

interface mem_port_if import soc_bus_pkg::*; ();

  // Request side
  logic      req;
  logic      we;
  bus_addr_t addr;
  bus_strb_t be;
  bus_data_t wdata;

  // Response, one cycle after req
  bus_data_t rdata;
  logic      rvalid;

  modport initiator (
    output req, we, addr, be, wdata,
    input  rdata, rvalid
  );

  modport target (
    input  req, we, addr, be, wdata,
    output rdata, rvalid
  );

endinterface

/* rtl/soc_map_pkg.sv */
/*
 * Address map types
 * Decoded bus targets and the register index of the control window
 */

package soc_map_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus targets
  //////////////////////////////////////////////////////////////////////

  // Destination of one request, NONE for an unmapped address
  typedef enum logic [1:0] {
    TGT_L2   = 2'd0,
    TGT_CTRL = 2'd1,
    TGT_NONE = 2'd2
  } soc_target_e;

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  // Selected by address bits 4:3, one 64-bit word per register
  typedef enum logic [1:0] {
    REG_EXIT      = 2'd0,
    REG_HW_CNT_EN = 2'd1,
    // Read-only DRAM window bounds
    REG_DRAM_BASE = 2'd2,
    REG_DRAM_END  = 2'd3
  } ctrl_reg_e;

endpackage

/* rtl/soc_bus_pkg.sv */
/*
 * Bus word types
 * Address, data and byte enable types plus the byte merge helper
 */

`include "soc_defs.svh"

package soc_bus_pkg;

  typedef logic [`SOC_ADDR_W-1:0] bus_addr_t;
  typedef logic [`SOC_DATA_W-1:0] bus_data_t;
  typedef logic [`SOC_STRB_W-1:0] bus_strb_t;

  // Replace only the bytes whose enable is set
  function automatic bus_data_t strb_merge(
    input bus_data_t old_word,
    input bus_data_t new_word,
    input bus_strb_t strb
  );
    bus_data_t merged;
    merged = old_word;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* include/soc_defs.svh */
/*
 * SoC memory-side definitions
 * Bus widths, L2 depth and the address map of the two targets
 */

`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Bus widths
`define SOC_ADDR_W    32
`define SOC_DATA_W    64
`define SOC_STRB_W    8

// L2 depth in words
`define SOC_L2_WORDS  1024

//////////////////////////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////////////////////////

// L2 window, 1024 words of 8 bytes
`define SOC_DRAM_BASE 32'h8000_0000
`define SOC_DRAM_LEN  32'h0000_2000

// Control register window
`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LEN  32'h0000_1000

`endif
